// ==== hw/apb_gpio.sv ====
// gpio slave with 2-flop input sync; pins must be stable for 2 clk_i cycles to be seen
`timescale 1ns/1ps

module apb_gpio (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  soc_periph_pkg::apb_req_t  apb_req_i,
  output soc_periph_pkg::apb_rsp_t  apb_rsp_o,
  input  soc_periph_pkg::gpio_vec_t gpio_in_i,
  output soc_periph_pkg::gpio_vec_t gpio_out_o,
  output soc_periph_pkg::gpio_vec_t gpio_oe_o,
  output soc_periph_pkg::gpio_vec_t gpio_evt_o
);

  logic                      wr_en;      // access phase write
  logic [7:0]                reg_ofs;
  soc_periph_pkg::gpio_vec_t wdata;
  soc_periph_pkg::gpio_vec_t dir_q;      // 1 = output
  soc_periph_pkg::gpio_vec_t out_q;
  soc_periph_pkg::gpio_vec_t irq_en_q;
  soc_periph_pkg::gpio_vec_t sync1_q;    // first sync stage
  soc_periph_pkg::gpio_vec_t sync2_q;    // value seen by IN
  soc_periph_pkg::gpio_vec_t prev_q;     // sync2 one cycle back
  soc_periph_pkg::gpio_vec_t evt_q;

  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign reg_ofs = apb_req_i.paddr[7:0];
  assign wdata   = apb_req_i.pwdata[soc_periph_pkg::N_GPIO-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      evt_q    <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      evt_q   <= sync2_q & ~prev_q & irq_en_q;   // rising edge, enabled pins only
      if (wr_en) begin
        case (reg_ofs)
          soc_periph_pkg::GPIO_DIR_OFS:    dir_q    <= wdata;
          soc_periph_pkg::GPIO_OUT_OFS:    out_q    <= wdata;
          soc_periph_pkg::GPIO_IRQ_EN_OFS: irq_en_q <= wdata;
          default: ;   // IN and holes ignore writes
        endcase
      end
    end
  end

  // read mux, no wait states
  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    case (reg_ofs)
      soc_periph_pkg::GPIO_DIR_OFS:    apb_rsp_o.prdata[soc_periph_pkg::N_GPIO-1:0] = dir_q;
      soc_periph_pkg::GPIO_OUT_OFS:    apb_rsp_o.prdata[soc_periph_pkg::N_GPIO-1:0] = out_q;
      soc_periph_pkg::GPIO_IN_OFS:     apb_rsp_o.prdata[soc_periph_pkg::N_GPIO-1:0] = sync2_q;
      soc_periph_pkg::GPIO_IRQ_EN_OFS: apb_rsp_o.prdata[soc_periph_pkg::N_GPIO-1:0] = irq_en_q;
      default: ;   // holes read zero
    endcase
  end

  assign gpio_oe_o  = dir_q;
  assign gpio_out_o = out_q;
  assign gpio_evt_o = evt_q;

endmodule

// ==== hw/apb_periph_decoder.sv ====
// combinational slot decode on paddr[11:8]; upper address bits are ignored so the map aliases
`timescale 1ns/1ps

module apb_periph_decoder (
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output soc_periph_pkg::apb_req_t gpio_req_o,
  output soc_periph_pkg::apb_req_t timer_req_o,
  output soc_periph_pkg::apb_req_t event_req_o,
  input  soc_periph_pkg::apb_rsp_t gpio_rsp_i,
  input  soc_periph_pkg::apb_rsp_t timer_rsp_i,
  input  soc_periph_pkg::apb_rsp_t event_rsp_i
);

  logic [3:0] slot;   // peripheral select field

  assign slot = apb_req_i.paddr[11:8];

  // request side
  // every slave sees addr/data/penable, only one sees psel
  always_comb begin
    gpio_req_o       = apb_req_i;
    timer_req_o      = apb_req_i;
    event_req_o      = apb_req_i;
    gpio_req_o.psel  = apb_req_i.psel & (slot == soc_periph_pkg::SLOT_GPIO);
    timer_req_o.psel = apb_req_i.psel & (slot == soc_periph_pkg::SLOT_TIMER);
    event_req_o.psel = apb_req_i.psel & (slot == soc_periph_pkg::SLOT_EVENT);
  end

  // response side
  always_comb begin
    case (slot)
      soc_periph_pkg::SLOT_GPIO: begin
        apb_rsp_o = gpio_rsp_i;
      end
      soc_periph_pkg::SLOT_TIMER: begin
        apb_rsp_o = timer_rsp_i;
      end
      soc_periph_pkg::SLOT_EVENT: begin
        apb_rsp_o = event_rsp_i;
      end
      default: begin
        // unmapped slot answers at once with an error
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/apb_ref_timer.sv ====
// counts ref_clk_i rising edges; ref_clk_i must be slower than clk_i/4 for every edge to be seen
`timescale 1ns/1ps

module apb_ref_timer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  input  logic                     ref_clk_i,
  input  logic                     stoptimer_i,
  output logic                     timer_evt_o,
  output logic                     ref_rise_o,
  output logic                     ref_fall_o
);

  logic                                      wr_en;
  logic [7:0]                                reg_ofs;
  logic [2:0]                                ref_sync_q;   // 2 sync stages + delayed copy
  logic                                      rise_q;
  logic                                      fall_q;
  logic                                      enable_q;     // CTRL bit 0
  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] count_q;
  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] cmp_q;
  logic                                      tick;         // counted edge
  logic                                      match_q;

  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign reg_ofs = apb_req_i.paddr[7:0];
  assign tick    = rise_q & enable_q & ~stoptimer_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ref_sync_q <= '0;
      rise_q     <= 1'b0;
      fall_q     <= 1'b0;
      enable_q   <= 1'b0;
      count_q    <= '0;
      cmp_q      <= '1;     // all ones, never matches early
      match_q    <= 1'b0;
    end else begin
      ref_sync_q <= {ref_sync_q[1:0], ref_clk_i};
      rise_q     <= ref_sync_q[1] & ~ref_sync_q[2];
      fall_q     <= ~ref_sync_q[1] & ref_sync_q[2];
      match_q    <= tick & (count_q == cmp_q);
      // bus write wins over the count update
      if (wr_en && reg_ofs == soc_periph_pkg::TIMER_COUNT_OFS) begin
        count_q <= apb_req_i.pwdata;
      end else if (tick) begin
        count_q <= (count_q == cmp_q) ? '0 : count_q + 1'b1;   // wrap at compare
      end
      if (wr_en && reg_ofs == soc_periph_pkg::TIMER_CTRL_OFS) begin
        enable_q <= apb_req_i.pwdata[0];
      end
      if (wr_en && reg_ofs == soc_periph_pkg::TIMER_CMP_OFS) begin
        cmp_q <= apb_req_i.pwdata;
      end
    end
  end

  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    case (reg_ofs)
      soc_periph_pkg::TIMER_CTRL_OFS:  apb_rsp_o.prdata[0] = enable_q;
      soc_periph_pkg::TIMER_COUNT_OFS: apb_rsp_o.prdata    = count_q;
      soc_periph_pkg::TIMER_CMP_OFS:   apb_rsp_o.prdata    = cmp_q;
      default: ;
    endcase
  end

  assign timer_evt_o = match_q;
  assign ref_rise_o  = rise_q;
  assign ref_fall_o  = fall_q;

endmodule

// ==== hw/soc_event_generator.sv ====
// one id pushed per cycle with the lowest id first; a pulse on a still pending event is lost
`timescale 1ns/1ps

module soc_event_generator (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  soc_periph_pkg::apb_req_t  apb_req_i,
  output soc_periph_pkg::apb_rsp_t  apb_rsp_o,
  input  soc_event_pkg::event_vec_t events_i,
  output soc_event_pkg::event_id_t  cl_event_data_o,
  output logic                      cl_event_valid_o,
  input  logic                      cl_event_ready_i,
  output logic                      err_evt_o
);

  typedef logic [$clog2(soc_event_pkg::EVT_FIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(soc_event_pkg::EVT_FIFO_DEPTH+1)-1:0] cnt_t;

  logic                      wr_en;
  logic [7:0]                reg_ofs;
  soc_event_pkg::event_vec_t wdata;
  soc_event_pkg::event_vec_t mask_q;
  soc_event_pkg::event_vec_t pending_q;
  soc_event_pkg::event_vec_t lost_q;       // sticky
  soc_event_pkg::event_vec_t masked_evt;
  soc_event_pkg::event_vec_t push_clr;     // one-hot of the pushed id
  soc_event_pkg::event_vec_t lost_now;
  soc_event_pkg::event_id_t  push_id;
  soc_event_pkg::event_id_t  fifo_mem [soc_event_pkg::EVT_FIFO_DEPTH];
  ptr_t                      wr_ptr_q;
  ptr_t                      rd_ptr_q;
  cnt_t                      fill_q;
  logic                      fifo_full;
  logic                      push;
  logic                      pop;
  logic                      err_q;

  assign wr_en      = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign reg_ofs    = apb_req_i.paddr[7:0];
  assign wdata      = apb_req_i.pwdata[soc_event_pkg::N_EVENTS-1:0];
  assign masked_evt = events_i & mask_q;

  //////////////////////////////////////////////////
  // pending latch and priority pick
  //////////////////////////////////////////////////
  assign fifo_full = (fill_q == cnt_t'(soc_event_pkg::EVT_FIFO_DEPTH));
  assign push      = (|pending_q) & ~fifo_full;
  assign pop       = cl_event_valid_o & cl_event_ready_i;

  always_comb begin
    push_id = '0;
    // scan down so the lowest set bit is kept
    for (int i = soc_event_pkg::N_EVENTS - 1; i >= 0; i--) begin
      if (pending_q[i]) push_id = soc_event_pkg::event_id_t'(i);
    end
    push_clr = push ? (soc_event_pkg::event_vec_t'(1) << push_id) : '0;
  end

  // a pulse landing in the push cycle re-arms the bit and is kept
  assign lost_now = masked_evt & pending_q & ~push_clr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q    <= '0;
      pending_q <= '0;
      lost_q    <= '0;
      err_q     <= 1'b0;
    end else begin
      pending_q <= (pending_q & ~push_clr) | masked_evt;
      err_q     <= |lost_now;
      if (wr_en && reg_ofs == soc_periph_pkg::EVT_MASK_OFS) begin
        mask_q <= wdata;
      end
      if (wr_en && reg_ofs == soc_periph_pkg::EVT_LOST_OFS) begin
        lost_q <= (lost_q & ~wdata) | lost_now;   // new losses win over the clear
      end else begin
        lost_q <= lost_q | lost_now;
      end
    end
  end

  //////////////////////////////////////////////////
  // id fifo
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps, depth is a power of two
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      fill_q <= fill_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= push_id;
  end

  assign cl_event_valid_o = (fill_q != '0);
  assign cl_event_data_o  = fifo_mem[rd_ptr_q];   // head, stable until popped
  assign err_evt_o        = err_q;

  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    case (reg_ofs)
      soc_periph_pkg::EVT_MASK_OFS: apb_rsp_o.prdata[soc_event_pkg::N_EVENTS-1:0] = mask_q;
      soc_periph_pkg::EVT_LOST_OFS: apb_rsp_o.prdata[soc_event_pkg::N_EVENTS-1:0] = lost_q;
      default: ;
    endcase
  end

endmodule

// ==== hw/soc_event_pkg.sv ====
// event ids and fc event positions. ids must stay below N_EVENTS, fifo depth must be a power of two
package soc_event_pkg;

  localparam int N_EVENTS = 11;

  // event ids, gpio pins take 0 to 7
  localparam int EVT_GPIO_BASE = 0;
  localparam int EVT_TIMER     = 8;    // compare match
  localparam int EVT_REF_RISE  = 9;
  localparam int EVT_REF_FALL  = 10;

  localparam int EVNT_WIDTH     = 8;   // id width on the cluster port
  localparam int EVT_FIFO_DEPTH = 4;

  typedef logic [N_EVENTS-1:0]   event_vec_t;
  typedef logic [EVNT_WIDTH-1:0] event_id_t;

  // bit positions in fc_events_o
  localparam int FC_POS_MTIME    = 7;
  localparam int FC_POS_FIFO     = 11;  // id fifo not empty
  localparam int FC_POS_TIMER_LO = 16;
  localparam int FC_POS_REF_RISE = 18;
  localparam int FC_POS_REF_FALL = 19;
  localparam int FC_POS_ERR      = 31;  // lost event

endpackage

// ==== hw/soc_periph_pkg.sv ====
// bus definitions for the peripheral subsystem. APB3 with no wait states, 4 kB window, 256 B per slot
package soc_periph_pkg;

  //////////////////////////////////////////////////
  // apb widths and transfer structs
  //////////////////////////////////////////////////
  localparam int APB_ADDR_WIDTH = 32;
  localparam int APB_DATA_WIDTH = 32;
  localparam int N_GPIO         = 8;   // pins on the gpio block

  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // paddr[11:8] picks the peripheral
  localparam logic [3:0] SLOT_GPIO  = 4'd0;
  localparam logic [3:0] SLOT_TIMER = 4'd1;
  localparam logic [3:0] SLOT_EVENT = 4'd2;

  // register offsets, paddr[7:0]
  localparam logic [7:0] GPIO_DIR_OFS    = 8'h00;
  localparam logic [7:0] GPIO_OUT_OFS    = 8'h04;
  localparam logic [7:0] GPIO_IN_OFS     = 8'h08;   // read only
  localparam logic [7:0] GPIO_IRQ_EN_OFS = 8'h0C;
  localparam logic [7:0] TIMER_CTRL_OFS  = 8'h00;   // bit 0 enable
  localparam logic [7:0] TIMER_COUNT_OFS = 8'h04;
  localparam logic [7:0] TIMER_CMP_OFS   = 8'h08;
  localparam logic [7:0] EVT_MASK_OFS    = 8'h00;
  localparam logic [7:0] EVT_LOST_OFS    = 8'h04;   // write one to clear

  typedef logic [N_GPIO-1:0] gpio_vec_t;

endpackage

// ==== hw/soc_periph_top.sv ====
// peripheral subsystem top; single clock domain, ref_clk_i is sampled and not used as a clock
`timescale 1ns/1ps

module soc_periph_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      ref_clk_i,
  input  logic                      stoptimer_i,
  input  soc_periph_pkg::apb_req_t  apb_req_i,
  output soc_periph_pkg::apb_rsp_t  apb_rsp_o,
  input  soc_periph_pkg::gpio_vec_t gpio_in_i,
  output soc_periph_pkg::gpio_vec_t gpio_out_o,
  output soc_periph_pkg::gpio_vec_t gpio_oe_o,
  output logic [31:0]               fc_events_o,
  output soc_event_pkg::event_id_t  cl_event_data_o,
  output logic                      cl_event_valid_o,
  input  logic                      cl_event_ready_i
);

  soc_periph_pkg::apb_req_t  gpio_req;
  soc_periph_pkg::apb_req_t  timer_req;
  soc_periph_pkg::apb_req_t  event_req;
  soc_periph_pkg::apb_rsp_t  gpio_rsp;
  soc_periph_pkg::apb_rsp_t  timer_rsp;
  soc_periph_pkg::apb_rsp_t  event_rsp;
  soc_periph_pkg::gpio_vec_t gpio_evt;
  soc_event_pkg::event_vec_t events;
  logic                      timer_evt;
  logic                      ref_rise;
  logic                      ref_fall;
  logic                      err_evt;
  logic                      evt_valid;

  apb_periph_decoder i_decoder (
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .event_req_o (event_req),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .event_rsp_i (event_rsp)
  );

  apb_gpio i_gpio (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (gpio_req),
    .apb_rsp_o  (gpio_rsp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .gpio_evt_o (gpio_evt)
  );

  apb_ref_timer i_timer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (timer_req),
    .apb_rsp_o   (timer_rsp),
    .ref_clk_i   (ref_clk_i),
    .stoptimer_i (stoptimer_i),
    .timer_evt_o (timer_evt),
    .ref_rise_o  (ref_rise),
    .ref_fall_o  (ref_fall)
  );

  //////////////////////////////////////////////////
  // event routing
  //////////////////////////////////////////////////
  always_comb begin
    events = '0;
    events[soc_event_pkg::EVT_GPIO_BASE +: soc_periph_pkg::N_GPIO] = gpio_evt;   // ids 0..7
    events[soc_event_pkg::EVT_TIMER]    = timer_evt;
    events[soc_event_pkg::EVT_REF_RISE] = ref_rise;
    events[soc_event_pkg::EVT_REF_FALL] = ref_fall;
  end

  soc_event_generator i_event_gen (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .apb_req_i        (event_req),
    .apb_rsp_o        (event_rsp),
    .events_i         (events),
    .cl_event_data_o  (cl_event_data_o),
    .cl_event_valid_o (evt_valid),
    .cl_event_ready_i (cl_event_ready_i),
    .err_evt_o        (err_evt)
  );

  assign cl_event_valid_o = evt_valid;

  // fabric controller vector, unused positions tied low
  always_comb begin
    fc_events_o = '0;
    fc_events_o[soc_event_pkg::FC_POS_MTIME]    = timer_evt;   // mtime irq
    fc_events_o[soc_event_pkg::FC_POS_FIFO]     = evt_valid;
    fc_events_o[soc_event_pkg::FC_POS_TIMER_LO] = timer_evt;
    fc_events_o[soc_event_pkg::FC_POS_REF_RISE] = ref_rise;
    fc_events_o[soc_event_pkg::FC_POS_REF_FALL] = ref_fall;
    fc_events_o[soc_event_pkg::FC_POS_ERR]      = err_evt;     // lost event
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_soc_periph \
  -f soc_periph.f -o tb_soc_periph > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_periph > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$SIM_LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// ==== soc_periph.f ====
hw/soc_periph_pkg.sv
hw/soc_event_pkg.sv
hw/apb_periph_decoder.sv
hw/apb_gpio.sv
hw/apb_ref_timer.sv
hw/soc_event_generator.sv
hw/soc_periph_top.sv
testbench/tb_soc_periph.sv

// ==== testbench/tb_soc_periph.sv ====
// self-checking bench for soc_periph_top; ref clock period is 8 clk cycles, APB access takes 3
`timescale 1ns/1ps

module tb_soc_periph;

  localparam int CLK_PERIOD        = 100;
  localparam int REF_HALF          = 400;
  localparam int REF_PERIOD_CYCLES = 2 * REF_HALF / CLK_PERIOD;
  localparam int REF_SEEN_NS       = 3 * CLK_PERIOD;   // 2 sync flops + edge flop
  localparam int TIMER_CMP         = 3;
  localparam int N_OPS             = 7;
  localparam int N_EDGES           = 4;
  localparam int WATCHDOG_CYCLES   = 200 * (N_OPS + N_EDGES) + 2000;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;   // read back after the write
    logic        exp_err;
  } apb_op_t;

  logic                      clk;
  logic                      arst_n;
  logic                      ref_clk;
  logic                      stoptimer;
  logic                      cl_ready;
  soc_periph_pkg::apb_req_t  apb_req;
  soc_periph_pkg::apb_rsp_t  apb_rsp;
  soc_periph_pkg::gpio_vec_t gpio_in;
  soc_periph_pkg::gpio_vec_t gpio_out;
  soc_periph_pkg::gpio_vec_t gpio_oe;
  logic [31:0]               fc_events;
  soc_event_pkg::event_id_t  evt_data;
  logic                      evt_valid;

  apb_op_t                   ops [N_OPS];
  soc_periph_pkg::gpio_vec_t edges [N_EDGES];    // pins raised together
  soc_event_pkg::event_id_t  exp_ids [$];
  soc_periph_pkg::apb_rsp_t  rsp;                // last completed transfer
  int                        err_cnt;
  int                        timer_pulses;
  int                        lost_pulses;
  logic                      timer_mon;
  logic                      edge_mon;
  time                       last_pulse;
  time                       ref_rise_t;         // last ref_clk rising edge
  time                       ref_fall_t;

  soc_periph_top DUT (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .ref_clk_i        (ref_clk),
    .stoptimer_i      (stoptimer),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .gpio_in_i        (gpio_in),
    .gpio_out_o       (gpio_out),
    .gpio_oe_o        (gpio_oe),
    .fc_events_o      (fc_events),
    .cl_event_data_o  (evt_data),
    .cl_event_valid_o (evt_valid),
    .cl_event_ready_i (cl_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;
  always #(REF_HALF) ref_clk = ~ref_clk;   // flips on clk falling edges

  always @(posedge ref_clk) ref_rise_t = $time;
  always @(negedge ref_clk) ref_fall_t = $time;

  // match pulses must come CMP+1 ref periods apart
  always @(negedge clk) begin
    if (timer_mon && fc_events[soc_event_pkg::FC_POS_TIMER_LO]) begin
      if (timer_pulses > 0 &&
          ($time - last_pulse) != (TIMER_CMP + 1) * REF_PERIOD_CYCLES * CLK_PERIOD) begin
        $display("ERROR %0t fc_events_o[16] spacing: expected %0d, got %0t", $time,
                 (TIMER_CMP + 1) * REF_PERIOD_CYCLES * CLK_PERIOD, $time - last_pulse);
        err_cnt++;
      end
      timer_pulses++;
      last_pulse = $time;
    end
    if (fc_events[soc_event_pkg::FC_POS_ERR]) lost_pulses++;   // lost event pulse
  end

  // mtime copy, fifo flag and ref edges seen 3 cycles late
  always @(negedge clk) begin
    if (edge_mon) begin
      check_bit("fc_events_o[7]", fc_events[soc_event_pkg::FC_POS_TIMER_LO],
                fc_events[soc_event_pkg::FC_POS_MTIME]);
      check_bit("fc_events_o[11]", evt_valid, fc_events[soc_event_pkg::FC_POS_FIFO]);
      check_bit("fc_events_o[18]", ($time - ref_rise_t) == REF_SEEN_NS,
                fc_events[soc_event_pkg::FC_POS_REF_RISE]);
      check_bit("fc_events_o[19]", ($time - ref_fall_t) == REF_SEEN_NS,
                fc_events[soc_event_pkg::FC_POS_REF_FALL]);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////
  task automatic check_rsp(input string name, input soc_periph_pkg::apb_rsp_t exp,
                           input soc_periph_pkg::apb_rsp_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_gpio(input string name, input soc_periph_pkg::gpio_vec_t exp,
                            input soc_periph_pkg::gpio_vec_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_event(input string name, input soc_event_pkg::event_id_t exp,
                             input soc_event_pkg::event_id_t act);
    if (act !== exp) begin
      $display("ERROR %0t %s: expected %0d, got %0d", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t %s: expected %b, got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////
  // bus and event helpers
  ////////////////////////////////////////////////////
  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [7:0] ofs);
    return {20'd0, slot, ofs};
  endfunction

  // setup cycle, access cycle, response taken mid access cycle
  task automatic apb_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic write);
    int n;
    @(posedge clk);
    #10;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = write;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #10;
    apb_req.penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!apb_rsp.pready && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to %h got no pready within 16 cycles", addr);
      err_cnt++;
    end
    rsp = apb_rsp;
    @(posedge clk);
    #10;
    apb_req = '0;
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
    soc_periph_pkg::apb_rsp_t exp;
    exp = '{prdata: data, pready: 1'b1, pslverr: 1'b0};
    apb_access(addr, '0, 1'b0);
    check_rsp(name, exp, rsp);
  endtask

  // takes ids off the port while ready is high, in exp_ids order
  task automatic drain_ids(input string name);
    int n;
    n = 0;
    while (exp_ids.size() > 0 && n < 64) begin
      @(negedge clk);
      n++;
      if (evt_valid && cl_ready) check_event(name, exp_ids.pop_front(), evt_data);
    end
    if (exp_ids.size() > 0) begin
      $display("%s: %0d event ids never arrived", name, exp_ids.size());
      err_cnt++;
      exp_ids.delete();
    end
    repeat (4) @(negedge clk);
    check_bit({name, " valid after drain"}, 1'b0, evt_valid);   // nothing extra queued
  endtask

  initial begin
    int                       seed_val;
    soc_periph_pkg::apb_rsp_t exp_rsp;
    soc_periph_pkg::apb_rsp_t first_count;
    seed_val     = $urandom(40);
    clk          = 1'b0;
    ref_clk      = 1'b0;
    arst_n       = 1'b0;
    stoptimer    = 1'b0;
    cl_ready     = 1'b0;
    apb_req      = '0;
    gpio_in      = '0;
    err_cnt      = 0;
    timer_pulses = 0;
    lost_pulses  = 0;
    timer_mon    = 1'b0;
    edge_mon     = 1'b0;
    last_pulse   = 0;
    ref_rise_t   = 0;
    ref_fall_t   = 0;

    // register table, widths trim the read back value
    ops[0].addr = reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_DIR_OFS);
    ops[1].addr = reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_OUT_OFS);
    ops[2].addr = reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_IRQ_EN_OFS);
    ops[3].addr = reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CMP_OFS);
    ops[4].addr = reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_MASK_OFS);
    ops[5].addr = 32'h0000_0300;   // slot 3, unmapped
    ops[6].addr = 32'h0000_0F04;   // slot 15
    for (int i = 0; i < N_OPS; i++) begin
      ops[i].wdata   = $urandom;
      ops[i].exp_err = 1'b0;
    end
    ops[0].exp_rdata = ops[0].wdata & 32'h0000_00FF;
    ops[1].exp_rdata = ops[1].wdata & 32'h0000_00FF;
    ops[2].exp_rdata = ops[2].wdata & 32'h0000_00FF;
    ops[3].exp_rdata = ops[3].wdata;
    ops[4].exp_rdata = ops[4].wdata & 32'h0000_07FF;   // 11 events
    ops[5].exp_rdata = '0;
    ops[6].exp_rdata = '0;
    ops[5].exp_err   = 1'b1;
    ops[6].exp_err   = 1'b1;
    edges[0] = 8'h05;
    edges[1] = 8'h92;
    edges[2] = 8'hF0;
    edges[3] = soc_periph_pkg::gpio_vec_t'($urandom) | 8'h01;

    repeat (5) @(posedge clk);
    #10;
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("cl_event_valid_o after reset", 1'b0, evt_valid);
    check_gpio("gpio_oe_o after reset", '0, gpio_oe);
    check_gpio("gpio_out_o after reset", '0, gpio_out);
    check_bit("fc_events_o after reset", 1'b0, |fc_events);
    read_expect("DIR reset", reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_DIR_OFS), '0);
    read_expect("OUT reset", reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_OUT_OFS), '0);
    read_expect("IRQ_EN reset",
                reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_IRQ_EN_OFS), '0);
    read_expect("CTRL reset",
                reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CTRL_OFS), '0);
    read_expect("CMP reset", reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CMP_OFS),
                '1);
    read_expect("MASK reset", reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_MASK_OFS),
                '0);

    ////////////////////////////////////////////////////
    // register write and read back
    ////////////////////////////////////////////////////
    edge_mon = 1'b1;
    cl_ready = 1'b1;   // ref edge ids under the random MASK drain right away
    for (int i = 0; i < N_OPS; i++) begin
      apb_access(ops[i].addr, ops[i].wdata, 1'b1);
      check_bit($sformatf("op %0d write pready", i), 1'b1, rsp.pready);
      check_bit($sformatf("op %0d write pslverr", i), ops[i].exp_err, rsp.pslverr);
      apb_access(ops[i].addr, '0, 1'b0);
      exp_rsp = '{prdata: ops[i].exp_rdata, pready: 1'b1, pslverr: ops[i].exp_err};
      check_rsp($sformatf("op %0d read", i), exp_rsp, rsp);
    end
    check_gpio("gpio_oe_o", soc_periph_pkg::gpio_vec_t'(ops[0].wdata), gpio_oe);
    check_gpio("gpio_out_o", soc_periph_pkg::gpio_vec_t'(ops[1].wdata), gpio_out);
    apb_access(ops[2].addr, '0, 1'b1);   // no events from random inputs
    apb_access(ops[4].addr, '0, 1'b1);

    // gpio input through the synchronizer
    for (int i = 0; i < 4; i++) begin
      gpio_in = soc_periph_pkg::gpio_vec_t'($urandom);
      repeat (3) @(posedge clk);
      apb_access(reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_IN_OFS), '0, 1'b0);
      check_gpio("gpio IN", gpio_in, soc_periph_pkg::gpio_vec_t'(rsp.prdata));
    end

    ////////////////////////////////////////////////////
    // timer
    ////////////////////////////////////////////////////
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CMP_OFS), TIMER_CMP, 1'b1);
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_COUNT_OFS), '0, 1'b1);
    timer_mon = 1'b1;
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CTRL_OFS), 32'h1, 1'b1);
    for (int i = 0; i < 40; i++) begin   // 120 cycles, 15 ref edges
      apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_COUNT_OFS), '0, 1'b0);
      if (rsp.prdata > TIMER_CMP) begin
        $display("ERROR %0t timer COUNT: expected at most %0d, got %0d", $time, TIMER_CMP,
                 rsp.prdata);
        err_cnt++;
      end
    end
    timer_mon = 1'b0;
    if (timer_pulses < 3) begin
      $display("timer match pulsed %0d times over 15 ref edges, at least 3 due", timer_pulses);
      err_cnt++;
    end
    stoptimer = 1'b1;
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_COUNT_OFS), '0, 1'b0);
    first_count = rsp;
    repeat (3 * REF_PERIOD_CYCLES) @(posedge clk);
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_COUNT_OFS), '0, 1'b0);
    check_rsp("COUNT with stoptimer_i high", first_count, rsp);
    stoptimer = 1'b0;
    apb_access(reg_addr(soc_periph_pkg::SLOT_TIMER, soc_periph_pkg::TIMER_CTRL_OFS), '0, 1'b1);

    ////////////////////////////////////////////////////
    // event ordering and back-pressure
    ////////////////////////////////////////////////////
    apb_access(reg_addr(soc_periph_pkg::SLOT_GPIO, soc_periph_pkg::GPIO_IRQ_EN_OFS), 32'hFF, 1'b1);
    apb_access(reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_MASK_OFS), 32'hFF, 1'b1);
    cl_ready = 1'b1;
    for (int i = 0; i < N_EDGES; i++) begin
      @(posedge clk);
      #10;
      gpio_in = '0;
      repeat (4) @(posedge clk);
      #10;
      gpio_in = edges[i];
      for (int p = 0; p < soc_periph_pkg::N_GPIO; p++) begin
        if (edges[i][p]) begin
          exp_ids.push_back(soc_event_pkg::event_id_t'(soc_event_pkg::EVT_GPIO_BASE + p));
        end
      end
      drain_ids($sformatf("edge row %0d", i));
    end

    @(posedge clk);
    #10;
    cl_ready = 1'b0;
    gpio_in  = '0;
    repeat (4) @(posedge clk);
    #10;
    lost_pulses = 0;
    gpio_in = 8'h3F;   // ids 0..3 fill the fifo, 4 and 5 stay pending
    repeat (8) @(posedge clk);
    #10;
    gpio_in = '0;
    repeat (4) @(posedge clk);
    #10;
    gpio_in = 8'h70;   // 4 and 5 again while pending, 6 new
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_bit("valid under back-pressure", 1'b1, evt_valid);
    check_event("head under back-pressure", 8'd0, evt_data);
    if (lost_pulses != 1) begin
      $display("fc_events_o[31] pulsed %0d times, one pulse due for the lost pair", lost_pulses);
      err_cnt++;
    end
    read_expect("LOST", reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_LOST_OFS),
                32'h030);
    apb_access(reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_LOST_OFS), 32'h7FF, 1'b1);
    read_expect("LOST cleared", reg_addr(soc_periph_pkg::SLOT_EVENT, soc_periph_pkg::EVT_LOST_OFS),
                '0);
    // fifo, then pending
    for (int p = 0; p < 7; p++) begin
      exp_ids.push_back(soc_event_pkg::event_id_t'(p));
    end
    cl_ready = 1'b1;
    drain_ids("back-pressure drain");

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
